//--- ex_commit.sv
`timescale 1ns/100ps
`default_nettype none

`include "ex_params.svh"

module ex_commit (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                flush_i,
    input  logic                pause_i,
    input  logic                pause_mem_i,
    input  logic                dcache_pause_i,
    input  ex_pkg::ex_result_t  res0_i,
    input  ex_pkg::ex_result_t  res1_i,
    input  ex_pkg::ex_branch_t  br0_i,
    input  ex_pkg::ex_branch_t  br1_i,
    input  ex_pkg::ex_dreq_t    req0_i,
    input  ex_pkg::ex_dreq_t    req1_i,
    input  logic                busy0_i,
    input  logic                busy1_i,
    output ex_pkg::ex_result_t  mem0_o,
    output ex_pkg::ex_result_t  mem1_o,
    output ex_pkg::ex_dreq_t    dreq_o,
    output logic                pause_ex_o,
    output logic                branch_flush_o,
    output logic [`EX_XLEN-1:0] branch_target_o
);
    import ex_pkg::*;

    logic mis0;
    logic mis1;
    logic mem_op0;
    logic bubble;

    // ******************************
    // control outputs
    // ******************************

    assign pause_ex_o = busy0_i | busy1_i;

    assign mis0 = res0_i.valid && br0_i.mispredict;
    assign mis1 = res1_i.valid && br1_i.mispredict;

    // redirect only once both stages can move
    assign branch_flush_o  = (mis0 || mis1) && !pause_ex_o && !pause_mem_i;
    assign branch_target_o = mis0 ? br0_i.target : br1_i.target;

    // single cache port with lane 0 first
    assign mem_op0 = res0_i.valid && (req0_i.rd_en || (req0_i.wstrb != 4'h0));

    always_comb begin
        if (dcache_pause_i) begin
            dreq_o = '0;
        end else if (mem_op0) begin
            dreq_o = req0_i;
        end else begin
            dreq_o = req1_i;
        end
    end

    // ******************************
    // ex/mem register
    // ******************************

    // execute stalled on its own while memory drains
    assign bubble = pause_ex_o && !pause_mem_i;

    always_ff @(posedge clk) begin
        if (reset_i || flush_i || bubble) begin
            mem0_o.valid <= 1'b0;
            mem1_o.valid <= 1'b0;
        end else if (!pause_i) begin
            mem0_o <= res0_i;
            mem1_o <= res1_i;
            // younger slot is on the wrong path
            if (mis0) begin
                mem1_o.valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- ex_lane.sv
`timescale 1ns/100ps
`default_nettype none

`include "ex_params.svh"

module ex_lane (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               flush_i,
    input  logic               pause_i,
    input  ex_pkg::ex_issue_t  issue_i,
    output ex_pkg::ex_result_t result_o,
    output ex_pkg::ex_branch_t branch_o,
    output ex_pkg::ex_dreq_t   mem_req_o,
    output logic               busy_o
);
    import ex_pkg::*;

    localparam logic [`EX_XLEN-1:0] PC_STEP = 4;

    logic [`EX_XLEN-1:0]         alu_res;
    logic [`EX_XLEN-1:0]         product;
    logic [`EX_XLEN-1:0]         mem_addr;
    logic [`EX_XLEN-1:0]         br_target;
    logic [$clog2(`EX_XLEN)-1:0] shamt;
    logic                        mul_start;
    logic                        is_branch;
    logic                        taken;
    logic                        is_load;
    logic                        is_store;

    // ******************************
    // multiplier
    // ******************************

    assign mul_start = issue_i.valid && (issue_i.op == OP_MUL);

    ex_multiplier u_mul (
        .clk       (clk),
        .reset_i   (reset_i),
        .start_i   (mul_start),
        .pause_i   (pause_i),
        .flush_i   (flush_i),
        .a_i       (issue_i.src1),
        .b_i       (issue_i.src2),
        .busy_o    (busy_o),
        .product_o (product)
    );

    // ******************************
    // alu
    // ******************************

    assign shamt = issue_i.src2[$clog2(`EX_XLEN)-1:0];

    always_comb begin
        case (issue_i.op)
            OP_ADD:  alu_res = issue_i.src1 + issue_i.src2;
            OP_SUB:  alu_res = issue_i.src1 - issue_i.src2;
            OP_AND:  alu_res = issue_i.src1 & issue_i.src2;
            OP_OR:   alu_res = issue_i.src1 | issue_i.src2;
            OP_XOR:  alu_res = issue_i.src1 ^ issue_i.src2;
            OP_SLT:  alu_res = `EX_XLEN'($signed(issue_i.src1) < $signed(issue_i.src2));
            OP_SLL:  alu_res = issue_i.src1 << shamt;
            OP_SRL:  alu_res = issue_i.src1 >> shamt;
            OP_MUL:  alu_res = product;
            default: alu_res = '0;
        endcase
    end

    // ******************************
    // branch resolution
    // ******************************

    always_comb begin
        is_branch = 1'b0;
        taken     = 1'b0;
        case (issue_i.op)
            OP_BEQ: begin
                is_branch = issue_i.valid;
                taken     = (issue_i.src1 == issue_i.src2);
            end
            OP_BNE: begin
                is_branch = issue_i.valid;
                taken     = (issue_i.src1 != issue_i.src2);
            end
            OP_BLT: begin
                is_branch = issue_i.valid;
                taken     = ($signed(issue_i.src1) < $signed(issue_i.src2));
            end
            default: begin
                is_branch = 1'b0;
                taken     = 1'b0;
            end
        endcase
    end

    assign br_target = taken ? issue_i.pc + issue_i.imm : issue_i.pc + PC_STEP;

    // wrong direction, or right direction with a stale target
    assign branch_o.mispredict = is_branch &&
        ((taken != issue_i.pred_taken) || (taken && (br_target != issue_i.pred_target)));
    assign branch_o.target     = br_target;

    // ******************************
    // load / store
    // ******************************

    assign mem_addr = issue_i.src1 + issue_i.imm;
    assign is_load  = issue_i.valid && (issue_i.op == OP_LDW);
    assign is_store = issue_i.valid && (issue_i.op == OP_STW);

    assign mem_req_o.rd_en = is_load;
    assign mem_req_o.wstrb = is_store ? 4'hf : 4'h0;
    assign mem_req_o.addr  = (is_load || is_store) ? mem_addr : '0;
    assign mem_req_o.wdata = is_store ? issue_i.src2 : '0;

    assign result_o.valid      = issue_i.valid;
    assign result_o.pc         = issue_i.pc;
    assign result_o.op         = issue_i.op;
    assign result_o.rd         = issue_i.rd;
    assign result_o.rd_we      = issue_i.rd_we;
    assign result_o.result     = alu_res;
    assign result_o.mem_addr   = mem_addr;
    assign result_o.store_data = issue_i.src2;

endmodule

`default_nettype wire

//--- ex_multiplier.sv
`timescale 1ns/100ps
`default_nettype none

`include "ex_params.svh"

module ex_multiplier (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                start_i,
    input  logic                pause_i,
    input  logic                flush_i,
    input  logic [`EX_XLEN-1:0] a_i,
    input  logic [`EX_XLEN-1:0] b_i,
    output logic                busy_o,
    output logic [`EX_XLEN-1:0] product_o
);
    import ex_pkg::*;

    localparam int STEPS = `EX_MUL_STEPS;
    localparam int CNT_W = $clog2(STEPS);

    ex_mul_state_e       state_q;
    logic [CNT_W-1:0]    step_q;
    logic [`EX_XLEN-1:0] acc_q;
    logic [`EX_XLEN-1:0] mcand_q;
    logic [`EX_XLEN-1:0] mplier_q;
    logic                first;
    logic [`EX_XLEN-1:0] mcand;
    logic [`EX_XLEN-1:0] mplier;
    logic [`EX_XLEN-1:0] partial;

    // slice 0 comes straight from the operands in the start cycle
    assign first   = (state_q == MUL_IDLE);
    assign busy_o  = (first && start_i) || (state_q == MUL_RUN);
    assign mcand   = first ? a_i : mcand_q;
    assign mplier  = first ? b_i : mplier_q;
    assign partial = mcand * `EX_XLEN'(mplier[`EX_MUL_BITS-1:0]);

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            state_q <= MUL_IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                MUL_IDLE: begin
                    if (start_i) begin
                        state_q <= MUL_RUN;
                        step_q  <= CNT_W'(1);
                    end
                end
                MUL_RUN: begin
                    step_q <= step_q + CNT_W'(1);
                    if (step_q == CNT_W'(STEPS - 1)) begin
                        state_q <= MUL_DONE;
                    end
                end
                // wait out a global pause so a held MUL is not restarted
                MUL_DONE: begin
                    if (!pause_i) begin
                        state_q <= MUL_IDLE;
                    end
                end
                default: state_q <= MUL_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (busy_o) begin
            acc_q    <= (first ? '0 : acc_q) + partial;
            mcand_q  <= mcand << `EX_MUL_BITS;
            mplier_q <= mplier >> `EX_MUL_BITS;
        end
    end

    assign product_o = acc_q;

endmodule

`default_nettype wire

//--- ex_params.svh
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// datapath and address width
`define EX_XLEN 32

// architectural register index width
`define EX_REG_AW 5

// multiplier slice consumed per cycle
`define EX_MUL_BITS 8

// multiply latency in cycles
`define EX_MUL_STEPS (`EX_XLEN / `EX_MUL_BITS)

`endif

//--- ex_pkg.sv
`default_nettype none

`include "ex_params.svh"

package ex_pkg;

    // operation codes seen by each lane
    typedef enum logic [3:0] {
        OP_NOP = 4'd0,
        OP_ADD = 4'd1,
        OP_SUB = 4'd2,
        OP_AND = 4'd3,
        OP_OR  = 4'd4,
        OP_XOR = 4'd5,
        OP_SLT = 4'd6,
        OP_SLL = 4'd7,
        OP_SRL = 4'd8,
        OP_MUL = 4'd9,
        OP_BEQ = 4'd10,
        OP_BNE = 4'd11,
        OP_BLT = 4'd12,
        OP_LDW = 4'd13,
        OP_STW = 4'd14
    } ex_op_e;

    // multiplier sequencer
    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_RUN,
        MUL_DONE
    } ex_mul_state_e;

    // one issue slot from dispatch
    typedef struct packed {
        logic                   valid;
        logic [`EX_XLEN-1:0]    pc;
        ex_op_e                 op;
        logic [`EX_XLEN-1:0]    src1;
        logic [`EX_XLEN-1:0]    src2;
        logic [`EX_XLEN-1:0]    imm;
        logic [`EX_REG_AW-1:0]  rd;
        logic                   rd_we;
        logic                   pred_taken;
        logic [`EX_XLEN-1:0]    pred_target;
    } ex_issue_t;

    // lane outcome that is also the ex/mem register entry
    typedef struct packed {
        logic                   valid;
        logic [`EX_XLEN-1:0]    pc;
        ex_op_e                 op;
        logic [`EX_REG_AW-1:0]  rd;
        logic                   rd_we;
        logic [`EX_XLEN-1:0]    result;
        logic [`EX_XLEN-1:0]    mem_addr;
        logic [`EX_XLEN-1:0]    store_data;
    } ex_result_t;

    typedef struct packed {
        logic                   mispredict;
        logic [`EX_XLEN-1:0]    target;
    } ex_branch_t;

    // data cache request
    typedef struct packed {
        logic                   rd_en;
        logic [3:0]             wstrb;
        logic [`EX_XLEN-1:0]    addr;
        logic [`EX_XLEN-1:0]    wdata;
    } ex_dreq_t;

endpackage

`default_nettype wire

//--- execute.f
+incdir+.
ex_pkg.sv
ex_multiplier.sv
ex_lane.sv
ex_commit.sv
execute.sv
execute_assert.sv
tb_execute.sv

//--- execute.sv
`timescale 1ns/100ps
`default_nettype none

`include "ex_params.svh"

module execute (
    input  logic                clk,
    input  logic                reset_i,
    input  logic                flush_i,
    input  logic                pause_i,
    input  logic                pause_mem_i,
    input  logic                dcache_pause_i,
    input  ex_pkg::ex_issue_t   issue0_i,
    input  ex_pkg::ex_issue_t   issue1_i,
    output ex_pkg::ex_result_t  mem0_o,
    output ex_pkg::ex_result_t  mem1_o,
    output ex_pkg::ex_dreq_t    dreq_o,
    output logic                pause_ex_o,
    output logic                branch_flush_o,
    output logic [`EX_XLEN-1:0] branch_target_o
);
    import ex_pkg::*;

    ex_result_t res0;
    ex_result_t res1;
    ex_branch_t br0;
    ex_branch_t br1;
    ex_dreq_t   req0;
    ex_dreq_t   req1;
    logic       busy0;
    logic       busy1;

    // lane 0 holds the older slot
    ex_lane u_lane0 (
        .clk       (clk),
        .reset_i   (reset_i),
        .flush_i   (flush_i),
        .pause_i   (pause_i),
        .issue_i   (issue0_i),
        .result_o  (res0),
        .branch_o  (br0),
        .mem_req_o (req0),
        .busy_o    (busy0)
    );

    ex_lane u_lane1 (
        .clk       (clk),
        .reset_i   (reset_i),
        .flush_i   (flush_i),
        .pause_i   (pause_i),
        .issue_i   (issue1_i),
        .result_o  (res1),
        .branch_o  (br1),
        .mem_req_o (req1),
        .busy_o    (busy1)
    );

    ex_commit u_commit (
        .clk             (clk),
        .reset_i         (reset_i),
        .flush_i         (flush_i),
        .pause_i         (pause_i),
        .pause_mem_i     (pause_mem_i),
        .dcache_pause_i  (dcache_pause_i),
        .res0_i          (res0),
        .res1_i          (res1),
        .br0_i           (br0),
        .br1_i           (br1),
        .req0_i          (req0),
        .req1_i          (req1),
        .busy0_i         (busy0),
        .busy1_i         (busy1),
        .mem0_o          (mem0_o),
        .mem1_o          (mem1_o),
        .dreq_o          (dreq_o),
        .pause_ex_o      (pause_ex_o),
        .branch_flush_o  (branch_flush_o),
        .branch_target_o (branch_target_o)
    );

endmodule

`default_nettype wire

//--- execute_assert.sv
`timescale 1ns/100ps
`default_nettype none

`include "ex_params.svh"

module execute_assert (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               flush_i,
    input  logic               pause_mem_i,
    input  logic               dcache_pause_i,
    input  logic               pause_ex_i,
    input  logic               branch_flush_i,
    input  ex_pkg::ex_dreq_t   dreq_i,
    input  ex_pkg::ex_result_t mem0_i,
    input  ex_pkg::ex_result_t mem1_i
);
    import ex_pkg::*;

    localparam int STEPS = `EX_MUL_STEPS;

    // consecutive cycles with the stage paused
    int pause_run_q;

    always_ff @(posedge clk) begin
        if (reset_i || !pause_ex_i) begin
            pause_run_q <= 0;
        end else begin
            pause_run_q <= pause_run_q + 1;
        end
    end

    flush_needs_free_pipe: assert property (@(posedge clk) disable iff (reset_i)
        branch_flush_i |-> (!pause_ex_i && !pause_mem_i))
        else $error("branch flush raised while the pipeline is paused");

    dreq_quiet_on_cache_pause: assert property (@(posedge clk) disable iff (reset_i)
        dcache_pause_i |-> (dreq_i == '0))
        else $error("cache request not zero under dcache pause");

    flush_clears_valid: assert property (@(posedge clk) disable iff (reset_i)
        flush_i |=> (!mem0_i.valid && !mem1_i.valid))
        else $error("valid bit still set after flush");

    pause_bounded: assert property (@(posedge clk) disable iff (reset_i)
        pause_ex_i |-> (pause_run_q < STEPS))
        else $error("execute pause lasted longer than the multiply");

endmodule

bind execute execute_assert u_execute_assert (
    .clk            (clk),
    .reset_i        (reset_i),
    .flush_i        (flush_i),
    .pause_mem_i    (pause_mem_i),
    .dcache_pause_i (dcache_pause_i),
    .pause_ex_i     (pause_ex_o),
    .branch_flush_i (branch_flush_o),
    .dreq_i         (dreq_o),
    .mem0_i         (mem0_o),
    .mem1_i         (mem1_o)
);

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f execute.f --top-module tb_execute -o sim_execute \
    && ./obj_dir/sim_execute > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- tb_execute.sv
`timescale 1ns/100ps
`default_nettype none

`include "ex_params.svh"

module tb_execute;
    import ex_pkg::*;

    localparam int STEPS        = `EX_MUL_STEPS;
    localparam int RESET_CYCLES = 16;
    localparam int N_ALU        = 250;
    localparam int N_BR         = 250;
    localparam int N_MUL        = 40;
    localparam int N_MEM        = 200;
    localparam int N_DIRECTED   = 64;
    // twice the nominal run length
    localparam int CYCLE_LIMIT  = 2 * (RESET_CYCLES + N_ALU + N_BR + N_MUL * (STEPS + 1)
                                       + N_MEM + N_DIRECTED);

    logic                clk;
    logic                reset_i;
    logic                flush_i;
    logic                pause_i;
    logic                pause_mem_i;
    logic                dcache_pause_i;
    ex_issue_t           issue0_i;
    ex_issue_t           issue1_i;
    ex_result_t          mem0_o;
    ex_result_t          mem1_o;
    ex_dreq_t            dreq_o;
    logic                pause_ex_o;
    logic                branch_flush_o;
    logic [`EX_XLEN-1:0] branch_target_o;

    // reference model state
    ex_result_t          exp_mem0;
    ex_result_t          exp_mem1;
    ex_result_t          exp_res0;
    ex_result_t          exp_res1;
    ex_branch_t          exp_br0;
    ex_branch_t          exp_br1;
    ex_dreq_t            exp_dreq;
    logic                exp_busy0;
    logic                exp_busy1;
    logic                exp_pause;
    logic                exp_flush;
    logic [`EX_XLEN-1:0] exp_target;
    int                  mul_cnt0;
    int                  mul_cnt1;

    logic [31:0]         lfsr_q;
    int                  error_count;
    int                  cycle_count;

    execute i_execute (
        .clk             (clk),
        .reset_i         (reset_i),
        .flush_i         (flush_i),
        .pause_i         (pause_i),
        .pause_mem_i     (pause_mem_i),
        .dcache_pause_i  (dcache_pause_i),
        .issue0_i        (issue0_i),
        .issue1_i        (issue1_i),
        .mem0_o          (mem0_o),
        .mem1_o          (mem1_o),
        .dreq_o          (dreq_o),
        .pause_ex_o      (pause_ex_o),
        .branch_flush_o  (branch_flush_o),
        .branch_target_o (branch_target_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ******************************
    // stimulus helpers
    // ******************************

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            bits   = {bits[30:0], fb};
        end
        return bits;
    endfunction

    function automatic ex_issue_t random_slot(input ex_op_e op);
        ex_issue_t s;
        s.valid       = 1'b1;
        s.pc          = next_bits(30) << 2;
        s.op          = op;
        s.src1        = next_bits(32);
        s.src2        = next_bits(32);
        s.imm         = next_bits(32);
        s.rd          = `EX_REG_AW'(next_bits(`EX_REG_AW));
        s.rd_we       = 1'(next_bits(1));
        s.pred_taken  = 1'(next_bits(1));
        s.pred_target = next_bits(32);
        return s;
    endfunction

    function automatic ex_op_e alu_op();
        return ex_op_e'(4'(next_bits(3)) + 4'd1);
    endfunction

    // branch with a prediction that is right at least half the time
    function automatic ex_issue_t branch_slot();
        ex_issue_t  s;
        ex_branch_t b;
        logic [1:0] mode;
        s = random_slot(ex_op_e'(4'd10 + 4'(next_bits(2) % 3)));
        if (next_bits(1) == 1) begin
            s.src2 = s.src1;
        end
        s.pred_taken = branch_taken(s);
        b    = model_branch(s);
        mode = 2'(next_bits(2));
        s.pred_target = b.target;
        if (mode == 2'd2) begin
            s.pred_taken = !s.pred_taken;
        end else if (mode == 2'd3) begin
            s.pred_target = b.target + 32'd4;
        end
        return s;
    endfunction

    // ******************************
    // reference model
    // ******************************

    function automatic logic branch_taken(input ex_issue_t s);
        case (s.op)
            OP_BEQ:  return s.src1 == s.src2;
            OP_BNE:  return s.src1 != s.src2;
            OP_BLT:  return $signed(s.src1) < $signed(s.src2);
            default: return 1'b0;
        endcase
    endfunction

    function automatic ex_branch_t model_branch(input ex_issue_t s);
        ex_branch_t b;
        logic       tk;
        logic       is_br;
        tk           = branch_taken(s);
        is_br        = s.valid && (s.op inside {OP_BEQ, OP_BNE, OP_BLT});
        b.target     = tk ? s.pc + s.imm : s.pc + 32'd4;
        b.mispredict = is_br && ((tk != s.pred_taken) || (tk && b.target != s.pred_target));
        return b;
    endfunction

    function automatic ex_result_t model_result(input ex_issue_t s);
        ex_result_t r;
        r.valid      = s.valid;
        r.pc         = s.pc;
        r.op         = s.op;
        r.rd         = s.rd;
        r.rd_we      = s.rd_we;
        r.mem_addr   = s.src1 + s.imm;
        r.store_data = s.src2;
        case (s.op)
            OP_ADD:  r.result = s.src1 + s.src2;
            OP_SUB:  r.result = s.src1 - s.src2;
            OP_AND:  r.result = s.src1 & s.src2;
            OP_OR:   r.result = s.src1 | s.src2;
            OP_XOR:  r.result = s.src1 ^ s.src2;
            OP_SLT:  r.result = {31'b0, $signed(s.src1) < $signed(s.src2)};
            OP_SLL:  r.result = s.src1 << s.src2[4:0];
            OP_SRL:  r.result = s.src1 >> s.src2[4:0];
            OP_MUL:  r.result = s.src1 * s.src2;
            default: r.result = '0;
        endcase
        return r;
    endfunction

    function automatic ex_dreq_t model_req(input ex_issue_t s);
        ex_dreq_t q;
        q = '0;
        if (s.valid && s.op == OP_LDW) begin
            q.rd_en = 1'b1;
            q.addr  = s.src1 + s.imm;
        end else if (s.valid && s.op == OP_STW) begin
            q.wstrb = 4'hf;
            q.addr  = s.src1 + s.imm;
            q.wdata = s.src2;
        end
        return q;
    endfunction

    always_comb begin
        exp_res0   = model_result(issue0_i);
        exp_res1   = model_result(issue1_i);
        exp_br0    = model_branch(issue0_i);
        exp_br1    = model_branch(issue1_i);
        exp_busy0  = issue0_i.valid && issue0_i.op == OP_MUL && mul_cnt0 < STEPS;
        exp_busy1  = issue1_i.valid && issue1_i.op == OP_MUL && mul_cnt1 < STEPS;
        exp_pause  = exp_busy0 || exp_busy1;
        exp_flush  = (exp_br0.mispredict || exp_br1.mispredict) && !exp_pause && !pause_mem_i;
        exp_target = exp_br0.mispredict ? exp_br0.target : exp_br1.target;
        if (dcache_pause_i) begin
            exp_dreq = '0;
        end else if (issue0_i.valid && issue0_i.op inside {OP_LDW, OP_STW}) begin
            exp_dreq = model_req(issue0_i);
        end else begin
            exp_dreq = model_req(issue1_i);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            mul_cnt0 <= 0;
            mul_cnt1 <= 0;
        end else begin
            if (exp_busy0) begin
                mul_cnt0 <= mul_cnt0 + 1;
            end else if (mul_cnt0 == STEPS && !pause_i) begin
                mul_cnt0 <= 0;
            end
            if (exp_busy1) begin
                mul_cnt1 <= mul_cnt1 + 1;
            end else if (mul_cnt1 == STEPS && !pause_i) begin
                mul_cnt1 <= 0;
            end
        end
        if (reset_i || flush_i || (exp_pause && !pause_mem_i)) begin
            exp_mem0.valid <= 1'b0;
            exp_mem1.valid <= 1'b0;
        end else if (!pause_i) begin
            exp_mem0 <= exp_res0;
            exp_mem1 <= exp_res1;
            if (exp_br0.mispredict) begin
                exp_mem1.valid <= 1'b0;
            end
        end
    end

    // ******************************
    // checks
    // ******************************

    mem0_check: assert property (@(posedge clk) disable iff (reset_i)
        (mem0_o.valid == exp_mem0.valid) && (!exp_mem0.valid || mem0_o == exp_mem0))
    else begin
        error_count++;
        $display("Mismatch at %0t: mem0_o got %h expected %h",
                 $time, $sampled(mem0_o), $sampled(exp_mem0));
    end

    mem1_check: assert property (@(posedge clk) disable iff (reset_i)
        (mem1_o.valid == exp_mem1.valid) && (!exp_mem1.valid || mem1_o == exp_mem1))
    else begin
        error_count++;
        $display("Mismatch at %0t: mem1_o got %h expected %h",
                 $time, $sampled(mem1_o), $sampled(exp_mem1));
    end

    pause_check: assert property (@(posedge clk) disable iff (reset_i)
        pause_ex_o == exp_pause)
    else begin
        error_count++;
        $display("Mismatch at %0t: pause_ex_o got %b expected %b",
                 $time, $sampled(pause_ex_o), $sampled(exp_pause));
    end

    flush_check: assert property (@(posedge clk) disable iff (reset_i)
        branch_flush_o == exp_flush)
    else begin
        error_count++;
        $display("Mismatch at %0t: branch_flush_o got %b expected %b",
                 $time, $sampled(branch_flush_o), $sampled(exp_flush));
    end

    target_check: assert property (@(posedge clk) disable iff (reset_i)
        exp_flush |-> branch_target_o == exp_target)
    else begin
        error_count++;
        $display("Mismatch at %0t: branch_target_o got %h expected %h",
                 $time, $sampled(branch_target_o), $sampled(exp_target));
    end

    dreq_check: assert property (@(posedge clk) disable iff (reset_i)
        dreq_o == exp_dreq)
    else begin
        error_count++;
        $display("Mismatch at %0t: dreq_o got %h expected %h",
                 $time, $sampled(dreq_o), $sampled(exp_dreq));
    end

    // ******************************
    // sequences
    // ******************************

    // dispatch holds a pair until the stage takes it
    task automatic issue_pair(input ex_issue_t s0, input ex_issue_t s1);
        logic held;
        issue0_i = s0;
        issue1_i = s1;
        do begin
            @(negedge clk);
            held = pause_ex_o || pause_i;
            @(posedge clk);
            #2;
        end while (held);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles, %0d errors",
                     CYCLE_LIMIT, error_count);
            $display("sim failed");
            $finish;
        end
    end

    initial begin
        ex_issue_t s0;
        ex_issue_t s1;
        lfsr_q         = 32'h596c_d64c;
        error_count    = 0;
        cycle_count    = 0;
        reset_i        = 1'b1;
        flush_i        = 1'b0;
        pause_i        = 1'b0;
        pause_mem_i    = 1'b0;
        dcache_pause_i = 1'b0;
        issue0_i       = '0;
        issue1_i       = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset_i = 1'b0;

        for (int i = 0; i < N_ALU; i++) begin
            s0 = random_slot(alu_op());
            s1 = random_slot(alu_op());
            s0.valid = (next_bits(3) != 0);
            issue_pair(s0, s1);
        end

        // mispredicts in either lane with some under a memory pause
        for (int i = 0; i < N_BR; i++) begin
            s0 = (next_bits(1) == 1) ? branch_slot() : random_slot(alu_op());
            s1 = branch_slot();
            pause_mem_i = (next_bits(2) == 0);
            issue_pair(s0, s1);
        end
        pause_mem_i = 1'b0;

        for (int i = 0; i < N_MUL; i++) begin
            s0 = random_slot(OP_MUL);
            s1 = random_slot((next_bits(1) == 1) ? OP_MUL : alu_op());
            issue_pair(s0, s1);
        end

        for (int i = 0; i < N_MEM; i++) begin
            s0 = random_slot((next_bits(1) == 1) ? OP_LDW : OP_STW);
            s1 = random_slot((next_bits(1) == 1) ? OP_STW : alu_op());
            s0.valid = (next_bits(2) != 0);
            dcache_pause_i = (next_bits(2) == 0);
            issue_pair(s0, s1);
        end
        dcache_pause_i = 1'b0;

        // pause_i holds the register over a new pair
        issue_pair(random_slot(OP_ADD), random_slot(OP_XOR));
        pause_i  = 1'b1;
        issue0_i = random_slot(OP_SUB);
        issue1_i = random_slot(OP_OR);
        repeat (3) next_cycle();
        pause_i = 1'b0;
        next_cycle();

        // a multiply that finishes under pause_i must not start again
        issue0_i = random_slot(OP_MUL);
        issue1_i = random_slot(OP_MUL);
        pause_i  = 1'b1;
        repeat (STEPS + 2) next_cycle();
        pause_i = 1'b0;
        next_cycle();

        // flush_i discards the pair in flight
        issue0_i = random_slot(OP_SLT);
        issue1_i = random_slot(OP_SLL);
        flush_i  = 1'b1;
        next_cycle();
        flush_i = 1'b0;
        issue_pair(random_slot(OP_SRL), random_slot(OP_AND));

        // reset in the middle of traffic
        reset_i = 1'b1;
        repeat (2) next_cycle();
        reset_i = 1'b0;
        issue_pair('0, '0);
        repeat (2) next_cycle();

        $display("run done: %0d cycles, %0d errors", cycle_count, error_count);
        if (error_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
